/* axis_mux.f */
+incdir+include
design/axis_mux_pkg.sv
design/axis_stream_if.sv
design/axis_mux_config.sv
design/axis_mux_arbiter.sv
design/axis_mux_datapath.sv
design/axis_mux_top.sv
testbench/axis_mux_clkgen.sv
testbench/axis_mux_tb.sv

/* design/axis_mux_arbiter.sv */
/* Packet-locked arbiter
 * Fixed priority or round robin over enabled requests, grant held
 * from the first accepted beat until the tlast beat
 */
`timescale 1ns/1ps
`include "axis_mux_consts.svh"

module axis_mux_arbiter (
    input logic aclk,
    input logic rst_n,
    input axis_mux_pkg::input_mask_t req,
    input axis_mux_pkg::input_mask_t enable,
    input axis_mux_pkg::arb_mode_e mode,
    input logic beat_accept,
    input logic beat_last,
    output logic grant_valid,
    output axis_mux_pkg::input_idx_t grant_idx,
    output logic pkt_done
);
    import axis_mux_pkg::*;

    input_mask_t masked_req;
    input_idx_t fixed_idx;
    input_idx_t rr_idx;
    input_idx_t rr_ptr;         // Input granted for the last finished packet
    input_idx_t lock_idx;
    logic locked;

    // Enable only gates new choices, a locked packet ignores it
    assign masked_req = req & enable;

    // Lowest index wins
    always_comb begin
        fixed_idx = '0;
        for (int i = `AXIS_MUX_INPUTS - 1; i >= 0; i--) begin
            if (masked_req[i]) begin
                fixed_idx = input_idx_t'(i);
            end
        end
    end

    // First requester found after the pointer, wrapping around
    always_comb begin
        int cand;
        logic found;
        found = 1'b0;
        rr_idx = rr_ptr;
        for (int i = 1; i <= `AXIS_MUX_INPUTS; i++) begin
            cand = (int'(rr_ptr) + i) % `AXIS_MUX_INPUTS;
            if (!found && masked_req[cand]) begin
                rr_idx = input_idx_t'(cand);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        if (locked) begin
            grant_valid = 1'b1;
            grant_idx = lock_idx;
        end else begin
            grant_valid = |masked_req;
            grant_idx = (mode == ARB_FIXED) ? fixed_idx : rr_idx;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            locked <= 1'b0;
            pkt_done <= 1'b0;
            rr_ptr <= input_idx_t'(`AXIS_MUX_INPUTS - 1);  // Input 0 goes first
        end else begin
            pkt_done <= beat_accept && beat_last;
            if (beat_accept) begin
                locked <= !beat_last;       // Single-beat packets never lock
                if (beat_last) begin
                    rr_ptr <= grant_idx;
                end
            end
        end
    end

    // Winner captured on the first beat of a packet
    always_ff @(posedge aclk) begin
        if (beat_accept && !locked) begin
            lock_idx <= grant_idx;
        end
    end

endmodule

/* design/axis_mux_config.sv */
/* Configuration registers of the multiplexer
 * Input enable mask, arbitration mode and forwarded packet counter
 */
`timescale 1ns/1ps
`include "axis_mux_consts.svh"

module axis_mux_config (
    input logic aclk,
    input logic rst_n,
    input logic cfg_wr,
    input logic cfg_rd,
    input axis_mux_pkg::cfg_addr_t cfg_addr,
    input axis_mux_pkg::cfg_word_t cfg_wdata,
    output axis_mux_pkg::cfg_word_t cfg_rdata,
    input logic pkt_done,
    output axis_mux_pkg::input_mask_t enable,
    output axis_mux_pkg::arb_mode_e mode
);
    import axis_mux_pkg::*;

    cfg_word_t pkt_count;

    logic wr_enable;
    logic wr_mode;
    logic wr_count;

    // Address decode for writes
    assign wr_enable = cfg_wr && (cfg_addr == cfg_addr_t'(`AXIS_MUX_ADDR_ENABLE));
    assign wr_mode = cfg_wr && (cfg_addr == cfg_addr_t'(`AXIS_MUX_ADDR_MODE));
    assign wr_count = cfg_wr && (cfg_addr == cfg_addr_t'(`AXIS_MUX_ADDR_PKT_COUNT));

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            enable <= '1;           // All inputs on
            mode <= ARB_FIXED;
        end else begin
            if (wr_enable) begin
                enable <= cfg_wdata[`AXIS_MUX_INPUTS-1:0];
            end
            if (wr_mode) begin
                mode <= arb_mode_e'(cfg_wdata[0]);
            end
        end
    end

    // Packet counter, a write to its address clears it
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pkt_count <= '0;
        end else if (wr_count) begin
            pkt_count <= '0;
        end else if (pkt_done) begin
            pkt_count <= pkt_count + 1'b1;
        end
    end

    // Read mux, zero when no read is strobed
    always_comb begin
        cfg_rdata = '0;
        if (cfg_rd) begin
            case (cfg_addr)
                cfg_addr_t'(`AXIS_MUX_ADDR_ENABLE): cfg_rdata = cfg_word_t'(enable);
                cfg_addr_t'(`AXIS_MUX_ADDR_MODE): cfg_rdata = cfg_word_t'(mode);
                cfg_addr_t'(`AXIS_MUX_ADDR_PKT_COUNT): cfg_rdata = pkt_count;
                default: cfg_rdata = '0;    // Unmapped address
            endcase
        end
    end

endmodule

/* design/axis_mux_datapath.sv */
/* Multiplexer datapath
 * Steers tready to the granted input, selects its fields and holds
 * one beat in the registered output stage
 */
`timescale 1ns/1ps
`include "axis_mux_consts.svh"

module axis_mux_datapath (
    input logic aclk,
    input logic rst_n,
    axis_stream_if.sink rx [`AXIS_MUX_INPUTS],
    axis_stream_if.source tx,
    input logic grant_valid,
    input axis_mux_pkg::input_idx_t grant_idx,
    output logic beat_accept,
    output logic beat_last
);
    import axis_mux_pkg::*;

    // Flattened view of the input channels
    input_mask_t rx_valid;
    input_mask_t rx_last;
    input_mask_t rx_ready;
    tdata_t rx_data [`AXIS_MUX_INPUTS];
    byte_mask_t rx_keep [`AXIS_MUX_INPUTS];
    byte_mask_t rx_strb [`AXIS_MUX_INPUTS];
    tdest_t rx_dest [`AXIS_MUX_INPUTS];
    tuser_t rx_user [`AXIS_MUX_INPUTS];
    tid_t rx_id [`AXIS_MUX_INPUTS];

    logic out_valid;
    logic out_room;             // Output stage can take a beat this cycle
    logic out_last;
    tdata_t out_data;
    byte_mask_t out_keep;
    byte_mask_t out_strb;
    tdest_t out_dest;
    tuser_t out_user;
    tid_t out_id;

    for (genvar k = 0; k < `AXIS_MUX_INPUTS; k++) begin : g_rx
        assign rx_valid[k] = rx[k].tvalid;
        assign rx_last[k] = rx[k].tlast;
        assign rx_data[k] = rx[k].tdata;
        assign rx_keep[k] = rx[k].tkeep;
        assign rx_strb[k] = rx[k].tstrb;
        assign rx_dest[k] = rx[k].tdest;
        assign rx_user[k] = rx[k].tuser;
        assign rx_id[k] = rx[k].tid;
        assign rx[k].tready = rx_ready[k];
    end

    // Empty or draining this cycle, so no bubble between beats
    assign out_room = !out_valid || tx.tready;

    always_comb begin
        rx_ready = '0;
        if (grant_valid && out_room) begin
            rx_ready[grant_idx] = 1'b1;
        end
    end

    assign beat_accept = grant_valid && out_room && rx_valid[grant_idx];
    assign beat_last = rx_last[grant_idx];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (beat_accept) begin
            out_valid <= 1'b1;
        end else if (tx.tready) begin
            out_valid <= 1'b0;      // Drained with nothing behind it
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_accept) begin
            out_last <= rx_last[grant_idx];
            out_data <= rx_data[grant_idx];
            out_keep <= rx_keep[grant_idx];
            out_strb <= rx_strb[grant_idx];
            out_dest <= rx_dest[grant_idx];
            out_user <= rx_user[grant_idx];
            out_id <= rx_id[grant_idx];
        end
    end

    assign tx.tvalid = out_valid;
    assign tx.tlast = out_last;
    assign tx.tdata = out_data;
    assign tx.tkeep = out_keep;
    assign tx.tstrb = out_strb;
    assign tx.tdest = out_dest;
    assign tx.tuser = out_user;
    assign tx.tid = out_id;

endmodule

/* design/axis_mux_pkg.sv */
/* Shared types of the AXI4-Stream multiplexer
 * Stream field types, input mask and index, register port types
 * and the arbitration mode
 */
`include "axis_mux_consts.svh"

package axis_mux_pkg;

    // One data beat, byte addressable
    typedef logic [`AXIS_MUX_TDATA_BYTES-1:0][7:0] tdata_t;

    // Per-byte qualifier, used for tkeep and tstrb
    typedef logic [`AXIS_MUX_TDATA_BYTES-1:0] byte_mask_t;

    typedef logic [`AXIS_MUX_TDEST_WIDTH-1:0] tdest_t;
    typedef logic [`AXIS_MUX_TUSER_WIDTH-1:0] tuser_t;
    typedef logic [`AXIS_MUX_TID_WIDTH-1:0] tid_t;

    // One bit per input
    typedef logic [`AXIS_MUX_INPUTS-1:0] input_mask_t;
    typedef logic [$clog2(`AXIS_MUX_INPUTS)-1:0] input_idx_t;

    typedef enum logic {
        ARB_FIXED       = 1'b0,     // Lowest index wins
        ARB_ROUND_ROBIN = 1'b1      // Rotate after the last granted input
    } arb_mode_e;

    // Register port
    typedef logic [1:0] cfg_addr_t;
    typedef logic [31:0] cfg_word_t;

endpackage

/* design/axis_mux_top.sv */
/* Top level of the AXI4-Stream multiplexer
 * Maps the flat rx and tx ports onto stream interfaces and connects
 * the configuration block, arbiter and datapath
 */
`timescale 1ns/1ps
`include "axis_mux_consts.svh"

module axis_mux_top (
    input logic aclk,
    input logic rst_n,
    // Rx
    input axis_mux_pkg::input_mask_t rx_tvalid,
    input axis_mux_pkg::input_mask_t rx_tlast,
    input axis_mux_pkg::tdata_t [`AXIS_MUX_INPUTS-1:0] rx_tdata,
    input axis_mux_pkg::byte_mask_t [`AXIS_MUX_INPUTS-1:0] rx_tkeep,
    input axis_mux_pkg::byte_mask_t [`AXIS_MUX_INPUTS-1:0] rx_tstrb,
    input axis_mux_pkg::tdest_t [`AXIS_MUX_INPUTS-1:0] rx_tdest,
    input axis_mux_pkg::tuser_t [`AXIS_MUX_INPUTS-1:0] rx_tuser,
    input axis_mux_pkg::tid_t [`AXIS_MUX_INPUTS-1:0] rx_tid,
    output axis_mux_pkg::input_mask_t rx_tready,
    // Tx
    output logic tx_tvalid,
    output logic tx_tlast,
    output axis_mux_pkg::tdata_t tx_tdata,
    output axis_mux_pkg::byte_mask_t tx_tkeep,
    output axis_mux_pkg::byte_mask_t tx_tstrb,
    output axis_mux_pkg::tdest_t tx_tdest,
    output axis_mux_pkg::tuser_t tx_tuser,
    output axis_mux_pkg::tid_t tx_tid,
    input logic tx_tready,
    // Register port
    input logic cfg_wr,
    input logic cfg_rd,
    input axis_mux_pkg::cfg_addr_t cfg_addr,
    input axis_mux_pkg::cfg_word_t cfg_wdata,
    output axis_mux_pkg::cfg_word_t cfg_rdata
);
    axis_mux_pkg::input_mask_t enable;
    axis_mux_pkg::arb_mode_e mode;
    axis_mux_pkg::input_idx_t grant_idx;
    logic grant_valid;
    logic beat_accept;
    logic beat_last;
    logic pkt_done;

    axis_stream_if rx [`AXIS_MUX_INPUTS] (.aclk(aclk));
    axis_stream_if tx (.aclk(aclk));

    for (genvar k = 0; k < `AXIS_MUX_INPUTS; k++) begin : g_inputs
        assign rx[k].tvalid = rx_tvalid[k];
        assign rx[k].tlast = rx_tlast[k];
        assign rx[k].tdata = rx_tdata[k];
        assign rx[k].tkeep = rx_tkeep[k];
        assign rx[k].tstrb = rx_tstrb[k];
        assign rx[k].tdest = rx_tdest[k];
        assign rx[k].tuser = rx_tuser[k];
        assign rx[k].tid = rx_tid[k];
        assign rx_tready[k] = rx[k].tready;
    end

    // Output channel back to flat ports
    assign tx_tvalid = tx.tvalid;
    assign tx_tlast = tx.tlast;
    assign tx_tdata = tx.tdata;
    assign tx_tkeep = tx.tkeep;
    assign tx_tstrb = tx.tstrb;
    assign tx_tdest = tx.tdest;
    assign tx_tuser = tx.tuser;
    assign tx_tid = tx.tid;
    assign tx.tready = tx_tready;

    axis_mux_config u_config (
        .aclk(aclk),
        .rst_n(rst_n),
        .cfg_wr(cfg_wr),
        .cfg_rd(cfg_rd),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .pkt_done(pkt_done),
        .enable(enable),
        .mode(mode)
    );

    axis_mux_arbiter u_arbiter (
        .aclk(aclk),
        .rst_n(rst_n),
        .req(rx_tvalid),            // Raw tvalid bits, masked inside
        .enable(enable),
        .mode(mode),
        .beat_accept(beat_accept),
        .beat_last(beat_last),
        .grant_valid(grant_valid),
        .grant_idx(grant_idx),
        .pkt_done(pkt_done)
    );

    axis_mux_datapath u_datapath (
        .aclk(aclk),
        .rst_n(rst_n),
        .rx(rx),
        .tx(tx),
        .grant_valid(grant_valid),
        .grant_idx(grant_idx),
        .beat_accept(beat_accept),
        .beat_last(beat_last)
    );

endmodule

/* design/axis_stream_if.sv */
/* AXI4-Stream channel interface
 * Handshake, payload and sideband signals with source and sink modports
 */
`timescale 1ns/1ps

interface axis_stream_if (
    input logic aclk
);
    import axis_mux_pkg::*;

    logic tvalid;
    logic tready;
    logic tlast;                // Final beat of a packet
    tdata_t tdata;
    byte_mask_t tkeep;
    byte_mask_t tstrb;
    tdest_t tdest;
    tuser_t tuser;
    tid_t tid;

    // Drives the payload and tvalid, samples tready
    modport source (
        input aclk,
        input tready,
        output tvalid,
        output tlast,
        output tdata,
        output tkeep,
        output tstrb,
        output tdest,
        output tuser,
        output tid
    );

    // Applies back-pressure through tready
    modport sink (
        input aclk,
        output tready,
        input tvalid,
        input tlast,
        input tdata,
        input tkeep,
        input tstrb,
        input tdest,
        input tuser,
        input tid
    );

endinterface

/* include/axis_mux_consts.svh */
/* Sizing constants for the AXI4-Stream multiplexer
 * Input count, beat width, sideband widths and register addresses
 */
`ifndef AXIS_MUX_CONSTS_SVH
`define AXIS_MUX_CONSTS_SVH

`define AXIS_MUX_INPUTS 4           // Stream inputs merged onto one output
`define AXIS_MUX_TDATA_BYTES 4      // Bytes per beat

// Sideband field widths, carried unchanged from input to output
`define AXIS_MUX_TDEST_WIDTH 4
`define AXIS_MUX_TUSER_WIDTH 8
`define AXIS_MUX_TID_WIDTH 4

// Register map of the configuration port
`define AXIS_MUX_ADDR_ENABLE 0      // Input enable mask
`define AXIS_MUX_ADDR_MODE 1        // Arbitration mode
`define AXIS_MUX_ADDR_PKT_COUNT 2   // Forwarded packets, cleared by a write

`endif

/* run_sim.sh */
#!/bin/sh
# Builds the axis_mux testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f axis_mux.f --top-module axis_mux_tb \
    -Mdir obj_dir -o axis_mux_sim > build.log 2>&1 \
    && ./obj_dir/axis_mux_sim > sim.log 2>&1 \
    && grep -q "Simulation finished: PASS" sim.log \
    && echo "axis_mux: simulation passed" \
    || { echo "axis_mux: simulation failed, see build.log and sim.log"; exit 1; }

/* testbench/axis_mux_clkgen.sv */
/* Clock and reset source for the multiplexer testbench
 * 100 ns aclk, rst_n held low for two cycles
 */
`timescale 1ns/1ps

module axis_mux_clkgen (
    output logic aclk,
    output logic rst_n
);
    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;           // Released away from the sampling edge
    end

endmodule

/* testbench/axis_mux_tb.sv */
/* Testbench for the AXI4-Stream multiplexer
 * Per-input packet sources, reference ordering model, tx monitor,
 * register checks and a watchdog
 */
`timescale 1ns/1ps
`include "axis_mux_consts.svh"

module axis_mux_tb;
    import axis_mux_pkg::*;

    typedef struct packed {
        tdata_t data;
        byte_mask_t keep;
        byte_mask_t strb;
        logic last;
        tdest_t dest;
        tuser_t user;
        tid_t id;
    } beat_t;

    logic aclk;
    logic rst_n;
    input_mask_t rx_tvalid;
    input_mask_t rx_tlast;
    input_mask_t rx_tready;
    tdata_t [`AXIS_MUX_INPUTS-1:0] rx_tdata;
    byte_mask_t [`AXIS_MUX_INPUTS-1:0] rx_tkeep;
    byte_mask_t [`AXIS_MUX_INPUTS-1:0] rx_tstrb;
    tdest_t [`AXIS_MUX_INPUTS-1:0] rx_tdest;
    tuser_t [`AXIS_MUX_INPUTS-1:0] rx_tuser;
    tid_t [`AXIS_MUX_INPUTS-1:0] rx_tid;
    logic tx_tvalid;
    logic tx_tlast;
    tdata_t tx_tdata;
    byte_mask_t tx_tkeep;
    byte_mask_t tx_tstrb;
    tdest_t tx_tdest;
    tuser_t tx_tuser;
    tid_t tx_tid;
    logic tx_tready;
    logic cfg_wr;
    logic cfg_rd;
    cfg_addr_t cfg_addr;
    cfg_word_t cfg_wdata;
    cfg_word_t cfg_rdata;

    input_mask_t xfer = '0;     // Input handshakes at the last rising edge
    logic bp_on = 1'b0;         // Random back-pressure on tx_tready
    beat_t drive_q [`AXIS_MUX_INPUTS][$];
    beat_t pend_q [`AXIS_MUX_INPUTS][$];   // Not yet placed in the expected order
    beat_t exp_q [$];
    int seq_next [`AXIS_MUX_INPUTS];
    int last_seq [`AXIS_MUX_INPUTS];
    input_idx_t last_grant = input_idx_t'(`AXIS_MUX_INPUTS - 1);
    int total_beats = 0;
    int mon_pkts = 0;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    axis_mux_clkgen u_clkgen (.aclk(aclk), .rst_n(rst_n));

    axis_mux_top DUT (
        .aclk(aclk), .rst_n(rst_n),
        .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tdata(rx_tdata),
        .rx_tkeep(rx_tkeep), .rx_tstrb(rx_tstrb), .rx_tdest(rx_tdest),
        .rx_tuser(rx_tuser), .rx_tid(rx_tid), .rx_tready(rx_tready),
        .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tdata(tx_tdata),
        .tx_tkeep(tx_tkeep), .tx_tstrb(tx_tstrb), .tx_tdest(tx_tdest),
        .tx_tuser(tx_tuser), .tx_tid(tx_tid), .tx_tready(tx_tready),
        .cfg_wr(cfg_wr), .cfg_rd(cfg_rd), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    task automatic check_beat(input string name, input tdata_t want, input tdata_t got);
        if (got !== want) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t want, input byte_mask_t got);
        if (got !== want) begin
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input cfg_word_t want, input cfg_word_t got);
        if (got !== want) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
            errors++;
        end
    endtask

    // Packets in grant order, all pending inputs requesting at every choice
    function automatic input_idx_t build_expected(input arb_mode_e m, input input_mask_t en,
                                                  input input_idx_t start);
        input_idx_t ptr;
        int win;
        int cand;
        beat_t b;
        ptr = start;
        win = 0;
        while (win >= 0) begin
            win = -1;
            for (int k = 1; k <= `AXIS_MUX_INPUTS; k++) begin
                cand = (m == ARB_FIXED) ? k - 1 : (int'(ptr) + k) % `AXIS_MUX_INPUTS;
                if (win < 0 && en[cand] && pend_q[cand].size() != 0) begin
                    win = cand;
                end
            end
            if (win >= 0) begin
                do begin
                    b = pend_q[win].pop_front();
                    exp_q.push_back(b);
                end while (!b.last);
                ptr = input_idx_t'(win);
            end
        end
        return ptr;
    endfunction

    task automatic queue_packets(input int src, input int npkt);
        beat_t b;
        int len;
        for (int p = 0; p < npkt; p++) begin
            len = $urandom_range(1, 6);
            for (int n = 0; n < len; n++) begin
                b.data = tdata_t'({8'($urandom), 24'(seq_next[src])});  // Sequence in low bytes
                b.keep = byte_mask_t'($urandom);
                b.strb = byte_mask_t'($urandom);
                b.last = (n == len - 1);
                b.dest = tdest_t'($urandom);
                b.user = tuser_t'($urandom);
                b.id = tid_t'(src);
                seq_next[src]++;
                drive_q[src].push_back(b);
                pend_q[src].push_back(b);
                total_beats++;
            end
        end
    endtask

    // Holds each beat on its input until the handshake completes
    task automatic send_beats(input int src);
        beat_t b;
        rx_tvalid[src] = 1'b0;
        rx_tlast[src] = 1'b0;
        rx_tdata[src] = '0;
        rx_tkeep[src] = '0;
        rx_tstrb[src] = '0;
        rx_tdest[src] = '0;
        rx_tuser[src] = '0;
        rx_tid[src] = '0;
        forever begin
            @(negedge aclk);
            if (xfer[src]) begin
                b = drive_q[src].pop_front();
            end
            rx_tvalid[src] = (drive_q[src].size() != 0);
            if (drive_q[src].size() != 0) begin
                b = drive_q[src][0];
                rx_tlast[src] = b.last;
                rx_tdata[src] = b.data;
                rx_tkeep[src] = b.keep;
                rx_tstrb[src] = b.strb;
                rx_tdest[src] = b.dest;
                rx_tuser[src] = b.user;
                rx_tid[src] = b.id;
            end
        end
    endtask

    for (genvar g = 0; g < `AXIS_MUX_INPUTS; g++) begin : g_src
        initial send_beats(g);
    end

    always @(posedge aclk) begin
        xfer <= rx_tvalid & rx_tready;
    end

    always @(negedge aclk) begin
        tx_tready = bp_on ? 1'($urandom) : 1'b1;
    end

    always @(posedge aclk) begin : monitor
        beat_t want;
        int seq;
        if (rst_n && tx_tvalid && tx_tready) begin
            seq = int'(tx_tdata) & 32'h00FF_FFFF;
            if (exp_q.size() == 0) begin
                $display("Unexpected beat from input %0d on tx at %0t ns", tx_tid, $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                check_beat("tx_tdata", want.data, tx_tdata);
                check_mask("tx_tkeep", want.keep, tx_tkeep);
                check_mask("tx_tstrb", want.strb, tx_tstrb);
                check_word("tx_tlast", cfg_word_t'(want.last), cfg_word_t'(tx_tlast));
                check_word("tx_tdest", cfg_word_t'(want.dest), cfg_word_t'(tx_tdest));
                check_word("tx_tuser", cfg_word_t'(want.user), cfg_word_t'(tx_tuser));
                check_word("tx_tid", cfg_word_t'(want.id), cfg_word_t'(tx_tid));
            end
            if (seq <= last_seq[input_idx_t'(tx_tid)]) begin
                $display("Sequence number of input %0d went backwards at %0t ns", tx_tid, $time);
                errors++;
            end
            last_seq[input_idx_t'(tx_tid)] = seq;
            if (tx_tlast) mon_pkts++;
        end
    end

    // Allows four cycles per beat plus 20 us of slack
    initial begin : watchdog
        longint limit;
        limit = 20000;
        while ($time < limit) begin
            @(negedge aclk);
            limit = 20000 + 400 * longint'(total_beats);
        end
        $display("Timeout: the expected tx beats did not all arrive in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic write_reg(input int addr, input cfg_word_t data);
        @(negedge aclk);
        cfg_wr = 1'b1;
        cfg_addr = cfg_addr_t'(addr);
        cfg_wdata = data;
        @(negedge aclk);
        cfg_wr = 1'b0;
    endtask

    task automatic read_reg(input int addr, output cfg_word_t data);
        @(negedge aclk);
        cfg_rd = 1'b1;
        cfg_addr = cfg_addr_t'(addr);
        @(posedge aclk);
        data = cfg_rdata;
        @(negedge aclk);
        cfg_rd = 1'b0;
    endtask

    task automatic start_traffic(input arb_mode_e m, input input_mask_t en, input int npkt);
        @(posedge aclk);        // Sources all pick up their packets at the same falling edge
        for (int s = 0; s < `AXIS_MUX_INPUTS; s++) begin
            queue_packets(s, npkt);
        end
        last_grant = build_expected(m, en, last_grant);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge aclk);
        repeat (4) @(negedge aclk);
        @(posedge aclk);
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            passed++;
            $display("Test %s: passed", name);
        end else begin
            failed++;
            $display("Test %s: failed with %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        cfg_word_t rd;
        int mark;
        void'($urandom(96));
        tx_tready = 1'b1;
        cfg_wr = 1'b0;
        cfg_rd = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        for (int s = 0; s < `AXIS_MUX_INPUTS; s++) begin
            seq_next[s] = 0;
            last_seq[s] = -1;
        end
        wait (rst_n === 1'b1);

        mark = errors;
        start_traffic(ARB_FIXED, '1, 3);
        wait_drained();
        report_test("fixed priority", mark);

        mark = errors;
        write_reg(`AXIS_MUX_ADDR_MODE, cfg_word_t'(ARB_ROUND_ROBIN));
        start_traffic(ARB_ROUND_ROBIN, '1, 3);
        wait_drained();
        report_test("round robin", mark);

        mark = errors;
        bp_on = 1'b1;
        start_traffic(ARB_ROUND_ROBIN, '1, 4);
        wait_drained();
        bp_on = 1'b0;
        report_test("back-pressure", mark);

        // Input 2 masked, its packets wait until re-enabled
        mark = errors;
        write_reg(`AXIS_MUX_ADDR_ENABLE, 32'hB);
        start_traffic(ARB_ROUND_ROBIN, 4'b1011, 2);
        wait_drained();
        repeat (10) @(negedge aclk);
        if (drive_q[2].size() == 0) begin
            $display("Input 2 lost its packets while disabled");
            errors++;
        end
        last_grant = build_expected(ARB_ROUND_ROBIN, '1, last_grant);
        write_reg(`AXIS_MUX_ADDR_ENABLE, 32'hF);
        wait_drained();
        report_test("enable mask", mark);

        mark = errors;
        read_reg(`AXIS_MUX_ADDR_PKT_COUNT, rd);
        check_word("pkt_count", cfg_word_t'(mon_pkts), rd);
        write_reg(`AXIS_MUX_ADDR_PKT_COUNT, 32'hA5A5_A5A5);    // Any write data clears it
        read_reg(`AXIS_MUX_ADDR_PKT_COUNT, rd);
        check_word("pkt_count", 32'h0, rd);
        write_reg(`AXIS_MUX_ADDR_ENABLE, 32'h5);
        read_reg(`AXIS_MUX_ADDR_ENABLE, rd);
        check_word("enable", 32'h5, rd);
        read_reg(`AXIS_MUX_ADDR_MODE, rd);
        check_word("mode", cfg_word_t'(ARB_ROUND_ROBIN), rd);
        write_reg(`AXIS_MUX_ADDR_MODE, cfg_word_t'(ARB_FIXED));
        read_reg(`AXIS_MUX_ADDR_MODE, rd);
        check_word("mode", cfg_word_t'(ARB_FIXED), rd);
        report_test("registers", mark);

        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
